// ==== design/rvPkg.sv ====
package rvPkg;

    // Datapath and register file sizing
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs = 1 << regAddrWidth;

    // Instruction field widths
    localparam int opcodeWidth = 7;
    localparam int funct3Width = 3;

    // Base opcodes handled by the decoder
    typedef enum logic [opcodeWidth-1:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcodeT;

    // ALU operations with add at zero so a bubble decodes as add
    typedef enum logic [4:0] {
        aluAdd   = 5'd0,
        aluSub   = 5'd1,
        aluAnd   = 5'd2,
        aluOr    = 5'd3,
        aluXor   = 5'd4,
        aluSlt   = 5'd5,
        aluSltu  = 5'd6,
        aluSll   = 5'd7,
        aluSrl   = 5'd8,
        aluSra   = 5'd9,
        aluPassB = 5'd10
    } aluCtrlT;

    // Write-back source select
    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

endpackage

// ==== design/decodeStage.sv ====
module decodeStage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rvPkg::xlen-1:0]              instr,
    input  logic [rvPkg::xlen-1:0]              pcF,
    input  logic                                wbEnable,
    input  logic [rvPkg::regAddrWidth-1:0]      wbAddr,
    input  logic [rvPkg::xlen-1:0]              wbData,
    output logic                                regWriteD,
    output logic                                memWriteD,
    output logic                                aluSrcD,
    output logic                                jumpD,
    output logic                                branchD,
    output logic                                jalrD,
    output rvPkg::resultSrcT                    resultSrcD,
    output logic [rvPkg::funct3Width-1:0]       funct3D,
    output rvPkg::aluCtrlT                      aluCtrlD,
    output logic [rvPkg::xlen-1:0]              rd1D,
    output logic [rvPkg::xlen-1:0]              rd2D,
    output logic [rvPkg::xlen-1:0]              pcD,
    output logic [rvPkg::xlen-1:0]              immExtD,
    output logic [rvPkg::xlen-1:0]              pcPlus4D,
    output logic [rvPkg::regAddrWidth-1:0]      rdD,
    output logic [rvPkg::regAddrWidth-1:0]      rs1D,
    output logic [rvPkg::regAddrWidth-1:0]      rs2D
);

    rvPkg::opcodeT opcode;
    rvPkg::aluCtrlT aluFromFunct;
    logic funct7b5;
    logic [rvPkg::xlen-1:0] immI, immS, immB, immJ, immU;
    logic [rvPkg::xlen-1:0] regs [rvPkg::numRegs];

    assign opcode   = rvPkg::opcodeT'(instr[6:0]);
    assign funct3D  = instr[14:12];
    assign funct7b5 = instr[30];
    assign rdD      = instr[11:7];
    assign rs1D     = instr[19:15];
    assign rs2D     = instr[24:20];
    assign pcD      = pcF;
    assign pcPlus4D = pcF + rvPkg::xlen'(4);

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    // Register file where x0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rvPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEnable && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    assign rd1D = (rs1D == '0) ? '0 : regs[rs1D];
    assign rd2D = (rs2D == '0) ? '0 : regs[rs2D];

    // funct7 bit 5 selects sub only for R-type and sra for both
    always_comb begin
        case (funct3D)
            3'b000:  aluFromFunct = (opcode == rvPkg::opR && funct7b5) ? rvPkg::aluSub
                                                                        : rvPkg::aluAdd;
            3'b001:  aluFromFunct = rvPkg::aluSll;
            3'b010:  aluFromFunct = rvPkg::aluSlt;
            3'b011:  aluFromFunct = rvPkg::aluSltu;
            3'b100:  aluFromFunct = rvPkg::aluXor;
            3'b101:  aluFromFunct = funct7b5 ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  aluFromFunct = rvPkg::aluOr;
            default: aluFromFunct = rvPkg::aluAnd;
        endcase
    end

    // Main decoder
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        jumpD      = 1'b0;
        branchD    = 1'b0;
        jalrD      = 1'b0;
        resultSrcD = rvPkg::resAlu;
        aluCtrlD   = rvPkg::aluAdd;
        immExtD    = immI;
        case (opcode)
            rvPkg::opR: begin
                regWriteD = 1'b1;
                aluCtrlD  = aluFromFunct;
            end
            rvPkg::opImm: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluCtrlD  = aluFromFunct;
            end
            rvPkg::opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = rvPkg::resMem;
            end
            rvPkg::opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immExtD   = immS;
            end
            rvPkg::opBranch: begin
                branchD  = 1'b1;
                aluCtrlD = rvPkg::aluSub;
                immExtD  = immB;
            end
            rvPkg::opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = rvPkg::resPcPlus4;
                immExtD    = immJ;
            end
            rvPkg::opJalr: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                jalrD      = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = rvPkg::resPcPlus4;
            end
            rvPkg::opLui: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluCtrlD  = rvPkg::aluPassB;
                immExtD   = immU;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/decodeExecuteReg.sv ====
module decodeExecuteReg (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flushE,

    // Control
    input  logic                                regWriteD,
    input  rvPkg::resultSrcT                    resultSrcD,
    input  logic                                memWriteD,
    input  logic [rvPkg::funct3Width-1:0]       funct3D,
    input  rvPkg::aluCtrlT                      aluCtrlD,
    input  logic                                aluSrcD,
    input  logic                                jumpD,
    input  logic                                branchD,
    input  logic                                jalrD,
    output logic                                regWriteE,
    output rvPkg::resultSrcT                    resultSrcE,
    output logic                                memWriteE,
    output logic [rvPkg::funct3Width-1:0]       funct3E,
    output rvPkg::aluCtrlT                      aluCtrlE,
    output logic                                aluSrcE,
    output logic                                jumpE,
    output logic                                branchE,
    output logic                                jalrE,

    // Data
    input  logic [rvPkg::xlen-1:0]              rd1D,
    input  logic [rvPkg::xlen-1:0]              rd2D,
    input  logic [rvPkg::xlen-1:0]              pcD,
    input  logic [rvPkg::regAddrWidth-1:0]      rdD,
    input  logic [rvPkg::xlen-1:0]              immExtD,
    input  logic [rvPkg::xlen-1:0]              pcPlus4D,
    output logic [rvPkg::xlen-1:0]              rd1E,
    output logic [rvPkg::xlen-1:0]              rd2E,
    output logic [rvPkg::xlen-1:0]              pcE,
    output logic [rvPkg::regAddrWidth-1:0]      rdE,
    output logic [rvPkg::xlen-1:0]              immExtE,
    output logic [rvPkg::xlen-1:0]              pcPlus4E,

    // Hazard
    input  logic [rvPkg::regAddrWidth-1:0]      rs1D,
    input  logic [rvPkg::regAddrWidth-1:0]      rs2D,
    output logic [rvPkg::regAddrWidth-1:0]      rs1E,
    output logic [rvPkg::regAddrWidth-1:0]      rs2E
);

    always_ff @(posedge clk) begin
        if (reset || flushE) begin
            // Bubble that writes nothing and never branches
            regWriteE  <= 1'b0;
            resultSrcE <= rvPkg::resAlu;
            memWriteE  <= 1'b0;
            funct3E    <= '0;
            aluCtrlE   <= rvPkg::aluAdd;
            aluSrcE    <= 1'b0;
            jumpE      <= 1'b0;
            branchE    <= 1'b0;
            jalrE      <= 1'b0;
            rd1E       <= '0;
            rd2E       <= '0;
            pcE        <= '0;
            rdE        <= '0;
            immExtE    <= '0;
            pcPlus4E   <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
        end else begin
            regWriteE  <= regWriteD;
            resultSrcE <= resultSrcD;
            memWriteE  <= memWriteD;
            funct3E    <= funct3D;
            aluCtrlE   <= aluCtrlD;
            aluSrcE    <= aluSrcD;
            jumpE      <= jumpD;
            branchE    <= branchD;
            jalrE      <= jalrD;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            pcE        <= pcD;
            rdE        <= rdD;
            immExtE    <= immExtD;
            pcPlus4E   <= pcPlus4D;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
        end
    end

endmodule

// ==== design/executeStage.sv ====
module executeStage (
    input  rvPkg::aluCtrlT                      aluCtrlE,
    input  logic                                aluSrcE,
    input  logic                                jumpE,
    input  logic                                branchE,
    input  logic                                jalrE,
    input  logic [rvPkg::funct3Width-1:0]       funct3E,
    input  logic [rvPkg::xlen-1:0]              rd1E,
    input  logic [rvPkg::xlen-1:0]              rd2E,
    input  logic [rvPkg::xlen-1:0]              pcE,
    input  logic [rvPkg::xlen-1:0]              immExtE,
    output logic [rvPkg::xlen-1:0]              aluResultE,
    output logic [rvPkg::xlen-1:0]              pcTargetE,
    output logic                                pcSrcE
);

    logic [rvPkg::xlen-1:0] srcB;
    logic [4:0] shamt;
    logic isEqual, lessSigned, lessUnsigned;
    logic branchTaken;

    assign srcB  = aluSrcE ? immExtE : rd2E;
    assign shamt = srcB[4:0];

    always_comb begin
        case (aluCtrlE)
            rvPkg::aluAdd:   aluResultE = rd1E + srcB;
            rvPkg::aluSub:   aluResultE = rd1E - srcB;
            rvPkg::aluAnd:   aluResultE = rd1E & srcB;
            rvPkg::aluOr:    aluResultE = rd1E | srcB;
            rvPkg::aluXor:   aluResultE = rd1E ^ srcB;
            rvPkg::aluSlt:   aluResultE = {31'b0, $signed(rd1E) < $signed(srcB)};
            rvPkg::aluSltu:  aluResultE = {31'b0, rd1E < srcB};
            rvPkg::aluSll:   aluResultE = rd1E << shamt;
            rvPkg::aluSrl:   aluResultE = rd1E >> shamt;
            rvPkg::aluSra:   aluResultE = $unsigned($signed(rd1E) >>> shamt);
            rvPkg::aluPassB: aluResultE = srcB;
            default:         aluResultE = '0;
        endcase
    end

    // Branch compare on the register operands
    assign isEqual      = (rd1E == rd2E);
    assign lessSigned   = ($signed(rd1E) < $signed(rd2E));
    assign lessUnsigned = (rd1E < rd2E);

    always_comb begin
        case (funct3E)
            3'b000:  branchTaken = isEqual;
            3'b001:  branchTaken = !isEqual;
            3'b100:  branchTaken = lessSigned;
            3'b101:  branchTaken = !lessSigned;
            3'b110:  branchTaken = lessUnsigned;
            3'b111:  branchTaken = !lessUnsigned;
            default: branchTaken = 1'b0;
        endcase
    end

    // jalr target comes from the ALU sum with bit 0 cleared
    assign pcTargetE = jalrE ? {aluResultE[rvPkg::xlen-1:1], 1'b0} : pcE + immExtE;
    assign pcSrcE    = jumpE || (branchE && branchTaken);

endmodule

// ==== design/decodeExecuteTop.sv ====
module decodeExecuteTop (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rvPkg::xlen-1:0]              instr,
    input  logic [rvPkg::xlen-1:0]              pcF,
    input  logic                                wbEnable,
    input  logic [rvPkg::regAddrWidth-1:0]      wbAddr,
    input  logic [rvPkg::xlen-1:0]              wbData,
    input  logic                                flushE,
    output logic [rvPkg::xlen-1:0]              aluResultE,
    output logic [rvPkg::xlen-1:0]              writeDataE,
    output logic [rvPkg::regAddrWidth-1:0]      rdE,
    output logic                                regWriteE,
    output logic                                memWriteE,
    output rvPkg::resultSrcT                    resultSrcE,
    output logic [rvPkg::funct3Width-1:0]       funct3E,
    output logic [rvPkg::xlen-1:0]              pcPlus4E,
    output logic [rvPkg::xlen-1:0]              pcTargetE,
    output logic                                pcSrcE,
    output logic [rvPkg::regAddrWidth-1:0]      rs1E,
    output logic [rvPkg::regAddrWidth-1:0]      rs2E
);

    // Decode side
    logic regWriteD, memWriteD, aluSrcD, jumpD, branchD, jalrD;
    rvPkg::resultSrcT resultSrcD;
    rvPkg::aluCtrlT aluCtrlD;
    logic [rvPkg::funct3Width-1:0] funct3D;
    logic [rvPkg::xlen-1:0] rd1D, rd2D, pcD, immExtD, pcPlus4D;
    logic [rvPkg::regAddrWidth-1:0] rdD, rs1D, rs2D;

    // Execute side
    logic aluSrcE, jumpE, branchE, jalrE;
    rvPkg::aluCtrlT aluCtrlE;
    logic [rvPkg::xlen-1:0] rd1E, rd2E, pcE, immExtE;

    assign writeDataE = rd2E;

    decodeStage decodeStage_i (
        .clk(clk), .reset(reset), .instr(instr), .pcF(pcF),
        .wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData),
        .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD),
        .jumpD(jumpD), .branchD(branchD), .jalrD(jalrD),
        .resultSrcD(resultSrcD), .funct3D(funct3D), .aluCtrlD(aluCtrlD),
        .rd1D(rd1D), .rd2D(rd2D), .pcD(pcD), .immExtD(immExtD), .pcPlus4D(pcPlus4D),
        .rdD(rdD), .rs1D(rs1D), .rs2D(rs2D)
    );

    decodeExecuteReg decodeExecuteReg_i (
        .clk(clk), .reset(reset), .flushE(flushE),
        .regWriteD(regWriteD), .resultSrcD(resultSrcD), .memWriteD(memWriteD),
        .funct3D(funct3D), .aluCtrlD(aluCtrlD), .aluSrcD(aluSrcD),
        .jumpD(jumpD), .branchD(branchD), .jalrD(jalrD),
        .regWriteE(regWriteE), .resultSrcE(resultSrcE), .memWriteE(memWriteE),
        .funct3E(funct3E), .aluCtrlE(aluCtrlE), .aluSrcE(aluSrcE),
        .jumpE(jumpE), .branchE(branchE), .jalrE(jalrE),
        .rd1D(rd1D), .rd2D(rd2D), .pcD(pcD), .rdD(rdD),
        .immExtD(immExtD), .pcPlus4D(pcPlus4D),
        .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .rdE(rdE),
        .immExtE(immExtE), .pcPlus4E(pcPlus4E),
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E)
    );

    executeStage executeStage_i (
        .aluCtrlE(aluCtrlE), .aluSrcE(aluSrcE), .jumpE(jumpE),
        .branchE(branchE), .jalrE(jalrE), .funct3E(funct3E),
        .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .immExtE(immExtE),
        .aluResultE(aluResultE), .pcTargetE(pcTargetE), .pcSrcE(pcSrcE)
    );

endmodule

// ==== tb/clockGen.sv ====
module clockGen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

endmodule

// ==== tb/decodeExecuteMonitor.sv ====
module decodeExecuteMonitor (
    input  logic                           clk,
    input  logic                           checkEn,
    input  logic                           aluCare,
    input  logic                           targetCare,
    input  logic [rvPkg::xlen-1:0]         aluResultE, writeDataE, pcPlus4E, pcTargetE,
    input  logic [rvPkg::regAddrWidth-1:0] rdE, rs1E, rs2E,
    input  logic [2:0]                     funct3E,
    input  logic [1:0]                     resultSrcE,
    input  logic                           regWriteE, memWriteE, pcSrcE,
    input  logic [rvPkg::xlen-1:0]         expAlu, expWriteData, expPcPlus4, expPcTarget,
    input  logic [rvPkg::regAddrWidth-1:0] expRd, expRs1, expRs2,
    input  logic [2:0]                     expFunct3,
    input  logic [1:0]                     expResultSrc,
    input  logic                           expRegWrite, expMemWrite, expPcSrc,
    output int                             errorCount,
    output int                             checkCount
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s mismatch: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Sampled mid-cycle once the outputs have settled
    always @(negedge clk) begin
        if (checkEn) begin
            checks++;
            if (aluCare)
                compareField("aluResultE", aluResultE, expAlu);
            if (targetCare)
                compareField("pcTargetE", pcTargetE, expPcTarget);
            compareField("writeDataE", writeDataE, expWriteData);
            compareField("pcPlus4E", pcPlus4E, expPcPlus4);
            compareField("rdE", 32'(rdE), 32'(expRd));
            compareField("rs1E", 32'(rs1E), 32'(expRs1));
            compareField("rs2E", 32'(rs2E), 32'(expRs2));
            compareField("funct3E", 32'(funct3E), 32'(expFunct3));
            compareField("resultSrcE", 32'(resultSrcE), 32'(expResultSrc));
            compareField("regWriteE", 32'(regWriteE), 32'(expRegWrite));
            compareField("memWriteE", 32'(memWriteE), 32'(expMemWrite));
            compareField("pcSrcE", 32'(pcSrcE), 32'(expPcSrc));
        end
    end

endmodule

// ==== tb/decodeExecuteChk.sv ====
module decodeExecuteChk (
    input logic                           clk, reset, flushE,
    input logic                           regWriteE, memWriteE, jumpE, branchE,
    input logic [rvPkg::regAddrWidth-1:0] rdD, rdE
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // pcSrcE can only be high through jumpE or branchE
    bubbleAfterFlush: assert property (@(posedge clk)
        flushE |=> !regWriteE && !memWriteE && !jumpE && !branchE)
        else begin
            failCount++;
            $error("control fields not cleared after flush");
        end

    bubbleAfterReset: assert property (@(posedge clk)
        reset |=> !regWriteE && !memWriteE && !jumpE && !branchE)
        else begin
            failCount++;
            $error("control fields not cleared after reset");
        end

    rdPassesThrough: assert property (@(posedge clk)
        !reset && !flushE |=> rdE == $past(rdD))
        else begin
            failCount++;
            $error("rdE does not follow rdD");
        end

endmodule

bind decodeExecuteReg decodeExecuteChk regChk_i (
    .clk(clk), .reset(reset), .flushE(flushE),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .jumpE(jumpE), .branchE(branchE),
    .rdD(rdD), .rdE(rdE)
);

// ==== tb/decodeExecuteTb.sv ====
module decodeExecuteTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numRows = 30;
    localparam int resetCycles = 5;
    localparam int cycleLimit = numRows + resetCycles + 20;

    typedef struct packed {
        logic                           wbEnable;
        logic [rvPkg::regAddrWidth-1:0] wbAddr;
        logic [rvPkg::xlen-1:0]         instr;
        logic                           flush;
    } rowT;

    logic clk, reset, wbEnable, flushE;
    logic [31:0] instr, pcF, wbData;
    logic [4:0] wbAddr;
    logic [31:0] aluResultE, writeDataE, pcPlus4E, pcTargetE;
    logic [4:0] rdE, rs1E, rs2E;
    logic [2:0] funct3E;
    logic [1:0] resultSrcE;
    logic regWriteE, memWriteE, pcSrcE;

    // Expected outputs for the row now in execute
    logic checkEn, aluCare, targetCare;
    logic [31:0] expAlu, expWriteData, expPcPlus4, expPcTarget;
    logic [4:0] expRd, expRs1, expRs2;
    logic [2:0] expFunct3;
    logic [1:0] expResultSrc;
    logic expRegWrite, expMemWrite, expPcSrc;

    int errorCount, checkCount, assertFails;
    int cycles = 0;
    logic [31:0] modelRegs [32];
    logic [31:0] rngState;
    rowT rows [numRows];

    clockGen clockGen_i (.clk(clk));

    decodeExecuteTop decodeExecuteTop_i (
        .clk(clk), .reset(reset), .instr(instr), .pcF(pcF),
        .wbEnable(wbEnable), .wbAddr(wbAddr), .wbData(wbData), .flushE(flushE),
        .aluResultE(aluResultE), .writeDataE(writeDataE), .rdE(rdE),
        .regWriteE(regWriteE), .memWriteE(memWriteE), .resultSrcE(resultSrcE),
        .funct3E(funct3E), .pcPlus4E(pcPlus4E), .pcTargetE(pcTargetE),
        .pcSrcE(pcSrcE), .rs1E(rs1E), .rs2E(rs2E)
    );

    decodeExecuteMonitor decodeExecuteMonitor_i (
        .clk(clk), .checkEn(checkEn), .aluCare(aluCare), .targetCare(targetCare),
        .aluResultE(aluResultE), .writeDataE(writeDataE), .pcPlus4E(pcPlus4E),
        .pcTargetE(pcTargetE), .rdE(rdE), .rs1E(rs1E), .rs2E(rs2E),
        .funct3E(funct3E), .resultSrcE(resultSrcE), .regWriteE(regWriteE),
        .memWriteE(memWriteE), .pcSrcE(pcSrcE),
        .expAlu(expAlu), .expWriteData(expWriteData), .expPcPlus4(expPcPlus4),
        .expPcTarget(expPcTarget), .expRd(expRd), .expRs1(expRs1), .expRs2(expRs2),
        .expFunct3(expFunct3), .expResultSrc(expResultSrc), .expRegWrite(expRegWrite),
        .expMemWrite(expMemWrite), .expPcSrc(expPcSrc),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32I arithmetic by funct3 with alt picking sub or sra
    function automatic logic [31:0] aluOp(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return {31'b0, ($signed(x) < $signed(y))};
            3'b011:  return {31'b0, (x < y)};
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt)
                    return $unsigned($signed(x) >>> y[4:0]);
                return x >> y[4:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic predict(input rowT row, input logic [31:0] pc);
        logic [31:0] w, a, b, immI, immS, immB, immJ, immU;
        logic [2:0] f3;
        w = row.instr;
        f3 = w[14:12];
        a = (w[19:15] == 5'd0) ? 32'd0 : modelRegs[w[19:15]];
        b = (w[24:20] == 5'd0) ? 32'd0 : modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        immU = {w[31:12], 12'b0};
        expRd = w[11:7];
        expRs1 = w[19:15];
        expRs2 = w[24:20];
        expFunct3 = f3;
        expPcPlus4 = pc + 32'd4;
        expWriteData = b;
        expRegWrite = 1'b0;
        expMemWrite = 1'b0;
        expPcSrc = 1'b0;
        expResultSrc = rvPkg::resAlu;
        expAlu = '0;
        expPcTarget = '0;
        aluCare = 1'b1;
        targetCare = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                expRegWrite = 1'b1;
                expAlu = aluOp(f3, w[30], a, b);
            end
            7'b0010011: begin
                expRegWrite = 1'b1;
                expAlu = aluOp(f3, f3 == 3'b101 && w[30], a, immI);
            end
            7'b0000011: begin
                expRegWrite = 1'b1;
                expResultSrc = rvPkg::resMem;
                expAlu = a + immI;
            end
            7'b0100011: begin
                expMemWrite = 1'b1;
                expAlu = a + immS;
            end
            7'b1100011: begin
                aluCare = 1'b0;
                targetCare = 1'b1;
                expPcTarget = pc + immB;
                case (f3)
                    3'b000:  expPcSrc = (a == b);
                    3'b001:  expPcSrc = (a != b);
                    3'b100:  expPcSrc = ($signed(a) < $signed(b));
                    3'b101:  expPcSrc = ($signed(a) >= $signed(b));
                    3'b110:  expPcSrc = (a < b);
                    3'b111:  expPcSrc = (a >= b);
                    default: expPcSrc = 1'b0;
                endcase
            end
            7'b1101111: begin
                expRegWrite = 1'b1;
                expResultSrc = rvPkg::resPcPlus4;
                expPcSrc = 1'b1;
                aluCare = 1'b0;
                targetCare = 1'b1;
                expPcTarget = pc + immJ;
            end
            7'b1100111: begin
                expRegWrite = 1'b1;
                expResultSrc = rvPkg::resPcPlus4;
                expPcSrc = 1'b1;
                targetCare = 1'b1;
                expAlu = a + immI;
                expPcTarget = expAlu & ~32'd1;
            end
            7'b0110111: begin
                expRegWrite = 1'b1;
                expAlu = immU;
            end
            default: aluCare = 1'b0;
        endcase
        // A bubble zeroes every field
        if (row.flush) begin
            {expRd, expRs1, expRs2, expFunct3, expResultSrc} = '0;
            {expRegWrite, expMemWrite, expPcSrc} = '0;
            {expAlu, expWriteData, expPcPlus4, expPcTarget} = '0;
            aluCare = 1'b1;
            targetCare = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        instr = '0;
        pcF = '0;
        wbEnable = 1'b0;
        wbAddr = '0;
        wbData = '0;
        flushE = 1'b0;
        checkEn = 1'b0;
        aluCare = 1'b1;
        targetCare = 1'b1;
        {expRd, expRs1, expRs2, expFunct3, expResultSrc} = '0;
        {expRegWrite, expMemWrite, expPcSrc} = '0;
        {expAlu, expWriteData, expPcPlus4, expPcTarget} = '0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        rngState = 32'h13412cfa;
        // wbEnable, wbAddr, instr, flush
        rows = '{
            '{1'b1, 5'd1, 32'h12345337, 1'b0},  // lui x6
            '{1'b1, 5'd2, 32'hFFFFF3B7, 1'b0},  // lui x7, 0xfffff
            '{1'b1, 5'd3, 32'hFFB08413, 1'b0},  // addi x8, x1, -5
            '{1'b1, 5'd4, 32'h002084B3, 1'b0},  // add
            '{1'b1, 5'd0, 32'h40218533, 1'b0},  // sub with a write to x0
            '{1'b0, 5'd0, 32'h0020F5B3, 1'b0},  // and
            '{1'b0, 5'd0, 32'h0030E633, 1'b0},  // or
            '{1'b0, 5'd0, 32'h004146B3, 1'b0},  // xor
            '{1'b0, 5'd0, 32'h0020A733, 1'b0},  // slt
            '{1'b0, 5'd0, 32'h0020B7B3, 1'b0},  // sltu
            '{1'b0, 5'd0, 32'h00309833, 1'b0},  // sll
            '{1'b0, 5'd0, 32'h003158B3, 1'b0},  // srl
            '{1'b0, 5'd0, 32'h40315933, 1'b0},  // sra
            '{1'b0, 5'd0, 32'h001009B3, 1'b0},  // add x19, x0, x1
            '{1'b1, 5'd5, 32'hFFF12A13, 1'b0},  // slti -1
            '{1'b0, 5'd0, 32'h40415A93, 1'b0},  // srai 4
            '{1'b0, 5'd0, 32'h0080AB03, 1'b0},  // lw 8(x1)
            '{1'b1, 5'd2, 32'hFE20AE23, 1'b0},  // sw x2, -4(x1) while x2 is rewritten
            '{1'b1, 5'd6, 32'h002084B3, 1'b1},  // flushed add
            '{1'b0, 5'd0, 32'h00108863, 1'b0},  // beq x1, x1
            '{1'b0, 5'd0, 32'hFE209CE3, 1'b0},  // bne backward
            '{1'b0, 5'd0, 32'h0020C863, 1'b0},  // blt
            '{1'b0, 5'd0, 32'h0020D863, 1'b0},  // bge
            '{1'b0, 5'd0, 32'h0020E863, 1'b0},  // bltu
            '{1'b0, 5'd0, 32'h0020F863, 1'b0},  // bgeu
            '{1'b0, 5'd0, 32'h00208863, 1'b0},  // beq x1, x2
            '{1'b0, 5'd0, 32'h100000EF, 1'b0},  // jal x1, 0x100
            '{1'b0, 5'd0, 32'h00C182E7, 1'b0},  // jalr x5, 12(x3)
            '{1'b0, 5'd0, 32'hFFDFF06F, 1'b0},  // jal x0, -4
            '{1'b1, 5'd7, 32'h100000EF, 1'b1}   // flushed jal
        };

        @(posedge clk);
        #2;
        checkEn = 1'b1;
        repeat (resetCycles - 1) @(posedge clk);
        for (int k = 0; k <= numRows; k++) begin
            #2;
            if (k == 0) begin
                reset = 1'b0;
            end else begin
                // Predict from the old registers, then apply the write
                predict(rows[k-1], pcF);
                if (rows[k-1].wbEnable && rows[k-1].wbAddr != 5'd0)
                    modelRegs[rows[k-1].wbAddr] = wbData;
            end
            if (k < numRows) begin
                rngState = xorshift(rngState);
                instr = rows[k].instr;
                pcF = 32'h0000_1000 + 32'(k * 4);
                wbEnable = rows[k].wbEnable;
                wbAddr = rows[k].wbAddr;
                wbData = rngState;
                flushE = rows[k].flush;
                @(posedge clk);
            end else begin
                instr = '0;
                wbEnable = 1'b0;
                flushE = 1'b0;
            end
        end
        @(negedge clk);
        #1;
        assertFails = decodeExecuteTop_i.decodeExecuteReg_i.regChk_i.failCount;
        $display("Summary: %0d checks, %0d value errors, %0d assertion failures",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0 && checkCount > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/rvPkg.sv
design/decodeStage.sv
design/decodeExecuteReg.sv
design/executeStage.sv
design/decodeExecuteTop.sv
tb/clockGen.sv
tb/decodeExecuteMonitor.sv
tb/decodeExecuteChk.sv
tb/decodeExecuteTb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = decodeExecuteTb
FILELIST  = list.f
FLAGS     = --binary --assert --timescale 1ns/1ps --top-module $(TOP)
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD)
